// ==== verilog.f ====
conv_pkg.sv
conv_ctrl.sv
line_buffer.sv
conv_window.sv
adder_tree.sv
conv_top.sv
tb_conv.sv

// ==== Makefile ====
# Verilator build and run for the convolution engine testbench

VERILATOR ?= verilator
TOP       ?= tb_conv
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
PASS_MSG  ?= Simulation PASSED

SIM := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status is set by the search for the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_conv.sv ====
`timescale 1ns/100ps

module tb_conv;
	import conv_pkg::*;

	// two frames of 256 pixels (first with ~1/3 idle), ~120 apb transfers, drains
	localparam int max_cycles = 4000;

	logic         clk = 1'b0;
	logic         arst_n;
	logic         psel;
	logic         penable;
	logic         pwrite;
	logic [7:0]   paddr;
	logic [31:0]  pwdata;
	logic [31:0]  prdata;
	logic         pready;
	logic         pslverr;
	pixel_t       pix;
	logic         pix_valid;
	conv_result_t res;
	logic         res_valid;
	logic         busy;

	integer       seed = 72;
	int           cyc = 0;
	string        test_name = "reset";
	pixel_t       img [img_h][img_w];  // frame under test
	pixel_t       cf [n_coefs];        // model copy of the coefficients
	conv_result_t exp_q [$];           // expected results, raster order
	int           due_q [$];           // cycle each result is due
	int           n_got;
	int           err_val = 0;
	int           err_miss = 0;
	int           err_unexp = 0;
	int           err_slv = 0;

	conv_top UUT (.*);

	always #2 clk = ~clk;  // 4 ns period

	always @(posedge clk)
		cyc <= cyc + 1;

	initial begin
		wait (cyc >= max_cycles);
		$display("timeout: run stopped after %0d cycles", cyc);
		$display("Simulation FAILED");
		$finish;
	end

	task automatic step();
		@(posedge clk);
		#0.5;  // drive point
	endtask

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	function automatic logic [7:0] coef_addr(int i);
		return 8'(int'(REG_COEF0) + 4*i);  // one word per coefficient
	endfunction

	function automatic logic [31:0] status_word(logic b, logic d, int count);
		return {16'd0, 8'(count), 6'd0, d, b};
	endfunction

	task automatic check_result(string what, conv_result_t exp, conv_result_t act);
		if (act !== exp) begin
			err_val++;
			$display("FAIL %s: expected %0d at (%0d,%0d), actual %0d at (%0d,%0d)", what,
				exp.value, exp.pos.row, exp.pos.col, act.value, act.pos.row, act.pos.col);
		end
	endtask

	task automatic check_word(string what, logic [31:0] exp, logic [31:0] act);
		if (act !== exp) begin
			err_val++;
			$display("FAIL %s: expected 0x%08h, actual 0x%08h", what, exp, act);
		end
	endtask

	task automatic check_bit(string what, logic exp, logic act);
		if (act !== exp) begin
			err_val++;
			$display("FAIL %s: expected %b, actual %b", what, exp, act);
		end
	endtask

	task automatic check_slverr(logic [7:0] addr, logic exp, logic act);
		if (act !== exp) begin
			err_slv++;
			if (exp)
				$display("%s: no pslverr for access to 0x%02h", test_name, addr);
			else
				$display("%s: pslverr raised for access to 0x%02h", test_name, addr);
		end
	endtask

	// setup phase, then access phase; pready is always high
	task automatic apb_write(logic [7:0] addr, logic [31:0] data, logic exp_err);
		logic err;
		logic rdy;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		step();
		penable = 1'b1;
		@(negedge clk);
		err = pslverr;  // mid access cycle
		rdy = pready;
		step();
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		check_bit({test_name, " pready"}, 1'b1, rdy);
		check_slverr(addr, exp_err, err);
	endtask

	task automatic apb_read(logic [7:0] addr, output logic [31:0] data, input logic exp_err);
		logic err;
		logic rdy;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		step();
		penable = 1'b1;
		@(negedge clk);
		err  = pslverr;
		rdy  = pready;
		data = prdata;
		step();
		psel    = 1'b0;
		penable = 1'b0;
		check_bit({test_name, " pready"}, 1'b1, rdy);
		check_slverr(addr, exp_err, err);
	endtask

	task automatic load_coeffs();
		logic [31:0] w;
		for (int i = 0; i < n_coefs; i++) begin
			w     = rand_word();  // upper bits are junk, dropped by the dut
			cf[i] = w[pix_w-1:0];
			apb_write(coef_addr(i), w, 1'b0);
		end
	endtask

	task automatic verify_coeffs();
		logic [31:0] rd;
		for (int i = 0; i < n_coefs; i++) begin
			apb_read(coef_addr(i), rd, 1'b0);
			check_word($sformatf("%s coef %0d", test_name, i), 32'(int'(cf[i])), rd);
		end
	endtask

	// random frame plus model results for every full window
	task automatic make_frame();
		logic [31:0]  w;
		int           acc;
		conv_result_t e;
		exp_q.delete();
		due_q.delete();
		for (int r = 0; r < img_h; r++) begin
			for (int c = 0; c < img_w; c++) begin
				w         = rand_word();
				img[r][c] = w[pix_w-1:0];
			end
		end
		for (int r = k_size-1; r < img_h; r++) begin
			for (int c = k_size-1; c < img_w; c++) begin
				acc = 0;
				for (int x = 0; x < k_size; x++) begin
					for (int y = 0; y < k_size; y++)
						acc += int'(cf[k_size*x+y]) * int'(img[r-k_size+1+x][c-k_size+1+y]);
				end
				e.value   = acc;
				e.pos.row = pos_w'(r);  // bottom-right corner
				e.pos.col = pos_w'(c);
				exp_q.push_back(e);
			end
		end
	endtask

	task automatic send_frame(bit gaps, bit mid_start);
		logic [31:0] w;
		for (int r = 0; r < img_h; r++) begin
			for (int c = 0; c < img_w; c++) begin
				if (mid_start && r == img_h/2 && c == 0) begin
					pix_valid = 1'b0;
					apb_write(REG_CTRL, 32'h1, 1'b0);  // start in RUN, dropped
				end
				while (gaps && (rand_word() % 3) == 0) begin
					w         = rand_word();
					pix       = w[pix_w-1:0];  // noise, not valid
					pix_valid = 1'b0;
					step();
				end
				pix       = img[r][c];
				pix_valid = 1'b1;
				if (r >= k_size-1 && c >= k_size-1)
					due_q.push_back(cyc + 4);  // taken next edge, sum 3 edges later
				step();
			end
		end
		pix_valid = 1'b0;
	endtask

	// valid pixels while not in RUN, none may produce a result
	task automatic drive_ignored(int n);
		logic [31:0] w;
		for (int i = 0; i < n; i++) begin
			w         = rand_word();
			pix       = w[pix_w-1:0];
			pix_valid = 1'b1;
			step();
		end
		pix_valid = 1'b0;
	endtask

	task automatic drain_and_count();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < 16) begin
			step();
			waited++;
		end
		repeat (8) step();  // room for stray extras
		if (exp_q.size() != 0) begin
			err_miss += exp_q.size();
			$display("%s: %0d results never came out", test_name, exp_q.size());
			exp_q.delete();
			due_q.delete();
		end
		check_word({test_name, " result count"}, 32'(n_results), 32'(n_got));
	endtask

	// result monitor, mid cycle so res is settled
	always @(negedge clk) begin
		if (arst_n && res_valid) begin
			n_got++;
			if (exp_q.size() == 0) begin
				err_unexp++;
				$display("%s: unexpected result %0d at (%0d,%0d) in cycle %0d", test_name,
					res.value, res.pos.row, res.pos.col, cyc);
			end else begin
				check_result(test_name, exp_q.pop_front(), res);
				if (due_q.size() != 0)
					check_word({test_name, " latency"}, due_q.pop_front(), cyc);
			end
		end
	end

	initial begin
		logic [31:0] rd;
		arst_n    = 1'b0;
		psel      = 1'b0;
		penable   = 1'b0;
		pwrite    = 1'b0;
		paddr     = '0;
		pwdata    = '0;
		pix       = '0;
		pix_valid = 1'b0;
		n_got     = 0;
		repeat (10) @(posedge clk);
		#0.5 arst_n = 1'b1;

		test_name = "coef_rw";
		apb_read(REG_STATUS, rd, 1'b0);
		check_word("coef_rw status after reset", status_word(0, 0, 0), rd);
		load_coeffs();
		verify_coeffs();

		test_name = "slverr";
		apb_read(8'h08, rd, 1'b1);  // hole below the coefficients
		apb_read(8'h42, rd, 1'b1);  // misaligned
		apb_read(8'ha4, rd, 1'b1);  // one past coef 24
		apb_write(REG_STATUS, 32'hffff_ffff, 1'b1);
		apb_read(REG_STATUS, rd, 1'b0);
		check_word("slverr status unchanged", status_word(0, 0, 0), rd);

		test_name = "frame1";
		make_frame();
		n_got = 0;
		apb_write(REG_CTRL, 32'h1, 1'b0);
		apb_read(REG_STATUS, rd, 1'b0);
		check_word("frame1 status busy", status_word(1, 0, 0), rd);
		check_bit("frame1 busy pin", 1'b1, busy);
		apb_write(coef_addr(7), {24'd0, ~cf[7]}, 1'b1);  // locked while busy
		apb_read(coef_addr(7), rd, 1'b0);
		check_word("frame1 locked coef 7", 32'(int'(cf[7])), rd);
		send_frame(1'b1, 1'b1);
		drain_and_count();

		test_name = "idle_pix";
		apb_read(REG_STATUS, rd, 1'b0);
		check_word("idle_pix status done", status_word(0, 1, n_results), rd);
		check_bit("idle_pix busy pin", 1'b0, busy);
		drive_ignored(80);  // DONE, enough to reach a full window if taken
		apb_write(REG_CTRL, 32'h2, 1'b0);  // clear done, back to IDLE
		apb_read(REG_STATUS, rd, 1'b0);
		check_word("idle_pix status cleared", status_word(0, 0, n_results), rd);
		drive_ignored(80);  // IDLE
		repeat (6) step();
		check_word("idle_pix result count", 32'(n_results), 32'(n_got));

		test_name = "frame2";  // back to back pixels, new weights
		load_coeffs();
		verify_coeffs();
		make_frame();
		n_got = 0;
		apb_write(REG_CTRL, 32'h1, 1'b0);
		send_frame(1'b0, 1'b0);
		drain_and_count();
		apb_read(REG_STATUS, rd, 1'b0);
		check_word("frame2 status done", status_word(0, 1, n_results), rd);

		$display("errors: mismatch %0d, missing %0d, unexpected %0d, pslverr %0d",
			err_val, err_miss, err_unexp, err_slv);
		if (err_val + err_miss + err_unexp + err_slv == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== conv_top.sv ====
`timescale 1ns/100ps

module conv_top (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [7:0]             paddr,
	input  logic [31:0]            pwdata,
	output logic [31:0]            prdata,
	output logic                   pready,
	output logic                   pslverr,
	input  conv_pkg::pixel_t       pix,
	input  logic                   pix_valid,
	output conv_pkg::conv_result_t res,
	output logic                   res_valid,
	output logic                   busy
);
	import conv_pkg::*;

	coeff_bank_t coeffs;
	logic        take;
	logic        win_ok;
	pos_t        win_pos;
	column_t     column;
	prod_bank_t  prods;
	logic        prod_valid;
	pos_t        prod_pos;

	// registers, fsm, raster position
	conv_ctrl u_ctrl (
		.clk(clk), .arst_n(arst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.pix_valid(pix_valid), .res_valid(res_valid),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.coeffs(coeffs), .take(take), .win_ok(win_ok),
		.win_pos(win_pos), .busy(busy)
	);

	line_buffer u_lbuf (
		.clk(clk), .arst_n(arst_n), .take(take),
		.pix(pix), .column(column)
	);

	conv_window u_win (
		.clk(clk), .arst_n(arst_n), .take(take),
		.column(column), .coeffs(coeffs),
		.win_ok(win_ok), .win_pos(win_pos),
		.prods(prods), .prod_valid(prod_valid), .prod_pos(prod_pos)
	);

	// two more cycles to the final sum
	adder_tree u_tree (
		.clk(clk), .arst_n(arst_n),
		.prods(prods), .prod_valid(prod_valid), .prod_pos(prod_pos),
		.res(res), .res_valid(res_valid)
	);

endmodule

// ==== adder_tree.sv ====
`timescale 1ns/100ps

module adder_tree (
	input  logic                   clk,
	input  logic                   arst_n,
	input  conv_pkg::prod_bank_t   prods,
	input  logic                   prod_valid,
	input  conv_pkg::pos_t         prod_pos,
	output conv_pkg::conv_result_t res,
	output logic                   res_valid
);
	import conv_pkg::*;

	logic signed [acc_w-1:0] part [k_size];  // one partial per window row
	logic signed [acc_w-1:0] total;
	logic                    part_valid;
	pos_t                    part_pos;

	// sum of the five products of window row g
	function automatic logic signed [acc_w-1:0] row_sum(prod_bank_t p, int g);
		logic signed [acc_w-1:0] s;
		s = '0;
		for (int i = 0; i < k_size; i++)
			s += p[k_size*g+i];  // sign extends from 16 bits
		return s;
	endfunction

	// stage 1
	always_ff @(posedge clk) begin
		for (int g = 0; g < k_size; g++)
			part[g] <= row_sum(prods, g);
		part_pos <= prod_pos;
	end

	always_comb begin
		total = '0;
		for (int g = 0; g < k_size; g++)
			total += part[g];
	end

	// stage 2
	always_ff @(posedge clk) begin
		res.value <= total;
		res.pos   <= part_pos;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			part_valid <= 1'b0;
			res_valid  <= 1'b0;
		end else begin
			part_valid <= prod_valid;  // tracks stage 1
			res_valid  <= part_valid;
		end
	end

endmodule

// ==== conv_window.sv ====
`timescale 1ns/100ps

module conv_window (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  take,
	input  conv_pkg::column_t     column,
	input  conv_pkg::coeff_bank_t coeffs,
	input  logic                  win_ok,
	input  conv_pkg::pos_t        win_pos,
	output conv_pkg::prod_bank_t  prods,
	output logic                  prod_valid,
	output conv_pkg::pos_t        prod_pos
);
	import conv_pkg::*;

	// win[row][age], age 0 is the newest column
	pixel_t win [k_size][k_size];
	logic   win_valid;  // window just completed a valid position
	pos_t   win_tag;

	always_ff @(posedge clk) begin
		if (take) begin
			for (int x = 0; x < k_size; x++) begin
				for (int a = k_size-1; a > 0; a--)
					win[x][a] <= win[x][a-1];
			end
			win[0][0] <= column.p0;  // top row
			win[1][0] <= column.p1;
			win[2][0] <= column.p2;
			win[3][0] <= column.p3;
			win[4][0] <= column.p4;  // bottom row
			win_tag   <= win_pos;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			win_valid  <= 1'b0;
			prod_valid <= 1'b0;
		end else begin
			win_valid  <= take & win_ok;  // single cycle pulse
			prod_valid <= win_valid;
		end
	end

	// oldest column sits at age 4, i.e. window column 0
	always_ff @(posedge clk) begin
		for (int x = 0; x < k_size; x++) begin
			for (int y = 0; y < k_size; y++)
				prods[k_size*x+y] <= win[x][k_size-1-y] * coeffs[k_size*x+y];
		end
		prod_pos <= win_tag;
	end

endmodule

// ==== line_buffer.sv ====
`timescale 1ns/100ps

module line_buffer (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              take,
	input  conv_pkg::pixel_t  pix,
	output conv_pkg::column_t column
);
	import conv_pkg::*;

	// [0] holds the row four back, [3] the previous row
	pixel_t           row_mem [k_size-1][img_w];
	logic [pos_w-1:0] ptr;  // column being written

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			ptr <= '0;
		else if (take)
			ptr <= (ptr == pos_w'(img_w-1)) ? '0 : ptr + 1'b1;
	end

	// each row moves one memory down the chain
	// contents unreset, early windows get masked by win_ok
	always_ff @(posedge clk) begin
		if (take) begin
			for (int i = 0; i < k_size-2; i++)
				row_mem[i][ptr] <= row_mem[i+1][ptr];
			row_mem[k_size-2][ptr] <= pix;  // newest full row
		end
	end

	// vertical slice at the current column
	assign column.p0 = row_mem[0][ptr];
	assign column.p1 = row_mem[1][ptr];
	assign column.p2 = row_mem[2][ptr];
	assign column.p3 = row_mem[3][ptr];
	assign column.p4 = pix;  // live pixel, not yet stored

endmodule

// ==== conv_ctrl.sv ====
`timescale 1ns/100ps

module conv_ctrl (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [7:0]            paddr,
	input  logic [31:0]           pwdata,
	input  logic                  pix_valid,
	input  logic                  res_valid,
	output logic [31:0]           prdata,
	output logic                  pready,
	output logic                  pslverr,
	output conv_pkg::coeff_bank_t coeffs,
	output logic                  take,
	output logic                  win_ok,
	output conv_pkg::pos_t        win_pos,
	output logic                  busy
);
	import conv_pkg::*;

	ctrl_state_e      state;
	logic [pos_w-1:0] row;
	logic [pos_w-1:0] col;
	logic [7:0]       res_cnt;  // results delivered this frame
	logic             done;
	logic             access;
	logic             wr;
	logic             is_coef;
	logic             unmapped;
	logic [7:0]       coef_off;
	logic [4:0]       coef_idx;
	logic             start;
	logic             clr_done;
	logic             restart;
	logic             last_col;
	logic             last_pix;

	// apb decode
	assign access   = psel & penable;
	assign coef_off = paddr - REG_COEF0;
	assign coef_idx = coef_off[6:2];
	assign is_coef  = (paddr >= REG_COEF0) && (coef_off[7:2] < 6'(n_coefs))
		&& (paddr[1:0] == 2'b00);
	assign unmapped = !((paddr == REG_CTRL) || (paddr == REG_STATUS) || is_coef);

	assign pready  = 1'b1;  // zero wait states
	assign pslverr = access & (unmapped
		| (pwrite & (paddr == REG_STATUS))      // status is read only
		| (pwrite & is_coef & busy));           // coefficients locked while running
	assign wr = access & pwrite & ~pslverr;

	assign start    = wr & (paddr == REG_CTRL) & pwdata[0];
	assign clr_done = wr & (paddr == REG_CTRL) & pwdata[1];
	assign restart  = start & (state != RUN);  // start during RUN is dropped

	always_comb begin
		prdata = '0;  // ctrl reads as zero
		if (is_coef)
			prdata = {{(32-pix_w){coeffs[coef_idx][pix_w-1]}}, coeffs[coef_idx]};
		else if (paddr == REG_STATUS)
			prdata = {16'd0, res_cnt, 6'd0, done, busy};
	end

	always_ff @(posedge clk) begin
		if (wr && is_coef)
			coeffs[coef_idx] <= pwdata[pix_w-1:0];
	end

	// pixel acceptance and window tagging
	assign busy     = (state == RUN);
	assign take     = pix_valid & busy;
	assign last_col = (col == pos_w'(img_w-1));
	assign last_pix = last_col && (row == pos_w'(img_h-1));
	assign win_ok   = (row >= pos_w'(k_size-1)) && (col >= pos_w'(k_size-1));
	assign win_pos  = '{row: row, col: col};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			row   <= '0;
			col   <= '0;
		end else if (restart) begin
			state <= RUN;
			row   <= '0;
			col   <= '0;
		end else if (take) begin
			if (last_pix)
				state <= DONE;  // remaining results drain on their own
			if (last_col) begin
				col <= '0;
				row <= row + 1'b1;
			end else begin
				col <= col + 1'b1;
			end
		end else if (clr_done && state == DONE) begin
			state <= IDLE;
		end
	end

	// result counter, done rises with the last result of the frame
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			res_cnt <= '0;
			done    <= 1'b0;
		end else if (restart) begin
			res_cnt <= '0;
			done    <= 1'b0;
		end else begin
			if (res_valid)
				res_cnt <= res_cnt + 1'b1;
			if (res_valid && res_cnt == 8'(n_results-1))
				done <= 1'b1;
			else if (clr_done)
				done <= 1'b0;
		end
	end

endmodule

// ==== conv_pkg.sv ====
package conv_pkg;

	// image and kernel geometry, fixed at build time
	localparam int pix_w     = 8;   // pixel and coefficient width
	localparam int acc_w     = 32;  // result width
	localparam int img_w     = 16;
	localparam int img_h     = 16;
	localparam int k_size    = 5;
	localparam int n_coefs   = k_size * k_size;
	localparam int n_results = (img_w - k_size + 1) * (img_h - k_size + 1);  // 144
	localparam int pos_w     = 4;   // row/col index width

	typedef logic signed [pix_w-1:0]   pixel_t;
	typedef logic signed [2*pix_w-1:0] prod_t;  // one 8x8 signed product

	// one vertical slice of the window, p0 is the oldest row
	typedef struct packed {
		pixel_t p4;  // current row
		pixel_t p3;
		pixel_t p2;
		pixel_t p1;
		pixel_t p0;  // four rows back
	} column_t;

	// entry 5*x+y weights window row x, column y (top-left origin)
	typedef pixel_t [n_coefs-1:0] coeff_bank_t;
	typedef prod_t  [n_coefs-1:0] prod_bank_t;

	// bottom-right pixel of a window
	typedef struct packed {
		logic [pos_w-1:0] row;
		logic [pos_w-1:0] col;
	} pos_t;

	typedef struct packed {
		logic signed [acc_w-1:0] value;
		pos_t                    pos;
	} conv_result_t;

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		DONE
	} ctrl_state_e;

	// apb word addresses, coefficients follow REG_COEF0 one per word
	typedef enum logic [7:0] {
		REG_CTRL   = 8'h00,  // [0] start, [1] clear done
		REG_STATUS = 8'h04,  // [0] busy, [1] done, [15:8] result count
		REG_COEF0  = 8'h40   // up to 0xa0
	} reg_addr_e;

endpackage
